/* src/ex_defines.svh */
// datapath and address widths
// divider iteration count
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

`define DATA_WIDTH 32
`define ADDR_WIDTH 32

// one quotient bit per iteration
`define DIV_STEPS  `DATA_WIDTH

`endif

/* src/alu_pkg.sv */
// ALU opcode enum
// functional unit opcodes and request structs
`include "ex_defines.svh"

package alu_pkg;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        ALU_LUI, ALU_AUIPC,
        ALU_JAL, ALU_JALR,
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
        ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU,
        ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU,
        ALU_CSR
    } alu_op_e;

    typedef enum logic [1:0] {
        ARITH_ADD, ARITH_SUB, ARITH_LINK
    } arith_op_e;

    typedef enum logic [2:0] {
        BW_AND, BW_OR, BW_XOR, BW_SLL, BW_SRL, BW_SRA
    } bitwise_op_e;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] a;
        logic [`DATA_WIDTH-1:0] b;
        arith_op_e              op;
        logic [`ADDR_WIDTH-1:0] pc;
        // 16-bit instruction, link is pc+2
        logic                   half_inst;
    } arith_req_t;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] a;
        logic [4:0]             shamt;
        bitwise_op_e            op;
    } bitwise_req_t;

endpackage

/* src/ex_pkg.sv */
// load/store type enums
// ID/EX bundle and EX result structs
`include "ex_defines.svh"

package ex_pkg;

    typedef enum logic [2:0] {
        LD_NONE, LD_LB, LD_LH, LD_LW, LD_LBU, LD_LHU
    } ld_type_e;

    typedef enum logic [1:0] {
        ST_NONE, ST_SB, ST_SH, ST_SW
    } st_type_e;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] rs1_data;
        logic [`DATA_WIDTH-1:0] rs2_data;
        logic [`ADDR_WIDTH-1:0] pc;
        logic [`DATA_WIDTH-1:0] imm;
        logic                   sel_pc;
        logic                   sel_imm;
        alu_pkg::alu_op_e       alu_op;
        ld_type_e               ld_type;
        st_type_e               st_type;
        logic                   half_inst;
    } idex_t;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] alu_data;
        logic                   branch_taken;
        logic [`ADDR_WIDTH-1:0] branch_pc;
        logic                   ld_st;
    } ex_result_t;

endpackage

/* src/arith_unit.sv */
// arith_unit: add/sub, link address, branch and jump target
`timescale 1ns/10ps
`include "ex_defines.svh"

module arith_unit (
    input  alu_pkg::arith_req_t    req,
    output logic [`DATA_WIDTH-1:0] result,
    output logic [`ADDR_WIDTH-1:0] branch_target
);
    logic [`DATA_WIDTH-1:0] sum;
    logic [`ADDR_WIDTH-1:0] link_step;
    logic [`ADDR_WIDTH-1:0] link_addr;

    assign sum = req.a + req.b;

    // compressed instructions are 2 bytes long
    assign link_step = req.half_inst ? 'd2 : 'd4;
    assign link_addr = req.pc + link_step;

    always_comb begin
        case (req.op)
            alu_pkg::ARITH_SUB:  result = req.a - req.b;
            alu_pkg::ARITH_LINK: result = link_addr;
            default:             result = sum;
        endcase
    end

    // jumps use a + b with bit 0 cleared, branches pc + offset
    assign branch_target = (req.op == alu_pkg::ARITH_LINK) ?
                           {sum[`ADDR_WIDTH-1:1], 1'b0} : req.pc + req.b;

endmodule

/* src/bitwise_unit.sv */
// bitwise_unit: logic ops and shifts
`timescale 1ns/10ps
`include "ex_defines.svh"

module bitwise_unit (
    input  alu_pkg::bitwise_req_t  req,
    input  logic [`DATA_WIDTH-1:0] b,
    output logic [`DATA_WIDTH-1:0] result
);

    always_comb begin
        case (req.op)
            alu_pkg::BW_AND: result = req.a & b;
            alu_pkg::BW_OR:  result = req.a | b;
            alu_pkg::BW_XOR: result = req.a ^ b;
            alu_pkg::BW_SLL: result = req.a << req.shamt;
            alu_pkg::BW_SRL: result = req.a >> req.shamt;
            // sign bit fills from the left
            alu_pkg::BW_SRA: result = $signed(req.a) >>> req.shamt;
            default:         result = '0;
        endcase
    end

endmodule

/* src/seq_divider.sv */
// seq_divider: unsigned restoring divider
// one quotient bit per clock, DLEN iterations
`timescale 1ns/10ps
`include "ex_defines.svh"

module seq_divider #(
    parameter int DLEN = `DATA_WIDTH
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            start,
    input  logic [DLEN-1:0] dividend,
    input  logic [DLEN-1:0] divisor,
    output logic [DLEN-1:0] quotient,
    output logic [DLEN-1:0] remainder,
    output logic            ready
);
    localparam int CW = $clog2(DLEN + 1);

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE
    } state_e;

    state_e          state;
    state_e          state_nxt;
    logic [CW-1:0]   step_cnt;
    logic [DLEN-1:0] part_rem;
    logic [DLEN-1:0] quot_sr;
    logic [DLEN-1:0] dvsr;
    logic [DLEN:0]   shifted;
    logic [DLEN:0]   trial;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_nxt = BUSY;
                end
            end
            BUSY: begin
                // dropping start aborts the divide
                if (!start) begin
                    state_nxt = IDLE;
                end else if (step_cnt == CW'(DLEN - 1)) begin
                    state_nxt = DONE;
                end
            end
            DONE: begin
                if (!start) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            step_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (state == BUSY) begin
                step_cnt <= step_cnt + 1'b1;
            end else begin
                step_cnt <= '0;
            end
        end
    end

    // shift in next dividend bit, try subtracting divisor
    assign shifted = {part_rem, quot_sr[DLEN-1]};
    assign trial   = shifted - {1'b0, dvsr};

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            part_rem <= '0;
            quot_sr  <= dividend;
            dvsr     <= divisor;
        end else if (state == BUSY) begin
            // borrow set means restore
            part_rem <= trial[DLEN] ? shifted[DLEN-1:0] : trial[DLEN-1:0];
            quot_sr  <= {quot_sr[DLEN-2:0], ~trial[DLEN]};
        end
    end

    assign quotient  = quot_sr;
    assign remainder = part_rem;
    assign ready     = (state == DONE);

endmodule

/* src/alu_dispatcher.sv */
// operand select, unit requests, compare and multiply
// divide sign fix-up and result select
`timescale 1ns/10ps
`include "ex_defines.svh"

module alu_dispatcher (
    input  ex_pkg::idex_t             idex,
    input  logic [`DATA_WIDTH-1:0]    csr_rdata,
    input  logic                      dcache_en,
    input  logic [`DATA_WIDTH-1:0]    arith_result,
    input  logic [`ADDR_WIDTH-1:0]    branch_target,
    input  logic [`DATA_WIDTH-1:0]    bitwise_result,
    input  logic [`DATA_WIDTH-1:0]    div_quotient,
    input  logic [`DATA_WIDTH-1:0]    div_remainder,
    input  logic                      div_ready,
    output alu_pkg::arith_req_t       arith_req,
    output alu_pkg::bitwise_req_t     bitwise_req,
    output logic [`DATA_WIDTH-1:0]    div_dividend,
    output logic [`DATA_WIDTH-1:0]    div_divisor,
    output logic                      div_start,
    output ex_pkg::ex_result_t        ex_out
);
    logic [`DATA_WIDTH-1:0]            op_a;
    logic [`DATA_WIDTH-1:0]            op_b;
    logic                              is_branch;
    logic                              div_signed;
    logic                              a_neg;
    logic                              b_neg;
    logic [`DATA_WIDTH-1:0]            cmp_a;
    logic [`DATA_WIDTH-1:0]            cmp_b;
    logic                              lt_s;
    logic                              lt_u;
    logic                              eq;
    logic                              branch_cond;
    logic signed [`DATA_WIDTH:0]       mul_a;
    logic signed [`DATA_WIDTH:0]       mul_b;
    logic signed [2*`DATA_WIDTH-1:0]   mul_prod;
    logic [`DATA_WIDTH-1:0]            quot_fix;
    logic [`DATA_WIDTH-1:0]            rem_fix;
    logic [`DATA_WIDTH-1:0]            div_data;

    assign op_a = idex.sel_pc ? idex.pc : idex.rs1_data;
    assign op_b = idex.sel_imm ? idex.imm : idex.rs2_data;

    assign is_branch = idex.alu_op inside {alu_pkg::ALU_BEQ, alu_pkg::ALU_BNE,
        alu_pkg::ALU_BLT, alu_pkg::ALU_BGE, alu_pkg::ALU_BLTU, alu_pkg::ALU_BGEU};

    always_comb begin
        arith_req.a         = op_a;
        arith_req.b         = op_b;
        arith_req.op        = alu_pkg::ARITH_ADD;
        arith_req.pc        = idex.pc;
        arith_req.half_inst = idex.half_inst;
        case (idex.alu_op)
            alu_pkg::ALU_SUB: arith_req.op = alu_pkg::ARITH_SUB;
            alu_pkg::ALU_AUIPC: begin
                arith_req.a = idex.pc;
                arith_req.b = idex.imm;
            end
            // jump target is a + b while the result is the link address
            alu_pkg::ALU_JAL, alu_pkg::ALU_JALR: begin
                arith_req.op = alu_pkg::ARITH_LINK;
                arith_req.a  = (idex.alu_op == alu_pkg::ALU_JALR) ? idex.rs1_data : idex.pc;
                arith_req.b  = idex.imm;
            end
            default: begin
                if (is_branch) begin
                    arith_req.b = idex.imm;
                end
            end
        endcase
    end

    always_comb begin
        bitwise_req.a     = op_a;
        bitwise_req.shamt = op_b[4:0];
        case (idex.alu_op)
            alu_pkg::ALU_OR:  bitwise_req.op = alu_pkg::BW_OR;
            alu_pkg::ALU_XOR: bitwise_req.op = alu_pkg::BW_XOR;
            alu_pkg::ALU_SLL: bitwise_req.op = alu_pkg::BW_SLL;
            alu_pkg::ALU_SRL: bitwise_req.op = alu_pkg::BW_SRL;
            alu_pkg::ALU_SRA: bitwise_req.op = alu_pkg::BW_SRA;
            default:          bitwise_req.op = alu_pkg::BW_AND;
        endcase
    end

    // branches always compare the two registers
    assign cmp_a = is_branch ? idex.rs1_data : op_a;
    assign cmp_b = is_branch ? idex.rs2_data : op_b;
    assign eq    = (cmp_a == cmp_b);
    assign lt_s  = ($signed(cmp_a) < $signed(cmp_b));
    assign lt_u  = (cmp_a < cmp_b);

    always_comb begin
        case (idex.alu_op)
            alu_pkg::ALU_BEQ:  branch_cond = eq;
            alu_pkg::ALU_BNE:  branch_cond = !eq;
            alu_pkg::ALU_BLT:  branch_cond = lt_s;
            alu_pkg::ALU_BGE:  branch_cond = !lt_s;
            alu_pkg::ALU_BLTU: branch_cond = lt_u;
            alu_pkg::ALU_BGEU: branch_cond = !lt_u;
            alu_pkg::ALU_JAL, alu_pkg::ALU_JALR: branch_cond = 1'b1;
            default:           branch_cond = 1'b0;
        endcase
    end

    // one 33x33 signed multiplier covers all four variants
    assign mul_a = {(idex.alu_op inside {alu_pkg::ALU_MULH, alu_pkg::ALU_MULHSU})
                    & op_a[`DATA_WIDTH-1], op_a};
    assign mul_b = {(idex.alu_op == alu_pkg::ALU_MULH) & op_b[`DATA_WIDTH-1], op_b};
    assign mul_prod = mul_a * mul_b;

    assign div_start  = idex.alu_op inside {alu_pkg::ALU_DIV, alu_pkg::ALU_DIVU,
                                            alu_pkg::ALU_REM, alu_pkg::ALU_REMU};
    assign div_signed = idex.alu_op inside {alu_pkg::ALU_DIV, alu_pkg::ALU_REM};
    assign a_neg      = div_signed & op_a[`DATA_WIDTH-1];
    assign b_neg      = div_signed & op_b[`DATA_WIDTH-1];
    assign div_dividend = a_neg ? -op_a : op_a;
    assign div_divisor  = b_neg ? -op_b : op_b;

    always_comb begin
        if (op_b == '0) begin
            quot_fix = '1;
            rem_fix  = op_a;
        end else begin
            quot_fix = (a_neg ^ b_neg) ? -div_quotient : div_quotient;
            rem_fix  = a_neg ? -div_remainder : div_remainder;
        end
        if (!div_ready) begin
            div_data = '0;
        end else if (idex.alu_op inside {alu_pkg::ALU_REM, alu_pkg::ALU_REMU}) begin
            div_data = rem_fix;
        end else begin
            div_data = quot_fix;
        end
    end

    always_comb begin
        case (idex.alu_op)
            alu_pkg::ALU_ADD, alu_pkg::ALU_SUB, alu_pkg::ALU_AUIPC,
            alu_pkg::ALU_JAL, alu_pkg::ALU_JALR:
                ex_out.alu_data = arith_result;
            alu_pkg::ALU_AND, alu_pkg::ALU_OR, alu_pkg::ALU_XOR,
            alu_pkg::ALU_SLL, alu_pkg::ALU_SRL, alu_pkg::ALU_SRA:
                ex_out.alu_data = bitwise_result;
            alu_pkg::ALU_SLT:  ex_out.alu_data = {{(`DATA_WIDTH-1){1'b0}}, lt_s};
            alu_pkg::ALU_SLTU: ex_out.alu_data = {{(`DATA_WIDTH-1){1'b0}}, lt_u};
            alu_pkg::ALU_LUI:  ex_out.alu_data = idex.imm;
            alu_pkg::ALU_MUL:  ex_out.alu_data = mul_prod[`DATA_WIDTH-1:0];
            alu_pkg::ALU_MULH, alu_pkg::ALU_MULHSU, alu_pkg::ALU_MULHU:
                ex_out.alu_data = mul_prod[2*`DATA_WIDTH-1:`DATA_WIDTH];
            alu_pkg::ALU_DIV, alu_pkg::ALU_DIVU, alu_pkg::ALU_REM, alu_pkg::ALU_REMU:
                ex_out.alu_data = div_data;
            alu_pkg::ALU_CSR:  ex_out.alu_data = csr_rdata;
            default:           ex_out.alu_data = '0;
        endcase
        ex_out.branch_taken = branch_cond;
        ex_out.branch_pc    = branch_target;
        ex_out.ld_st        = dcache_en && (idex.ld_type != ex_pkg::LD_NONE ||
                                            idex.st_type != ex_pkg::ST_NONE);
    end

endmodule

/* src/ex_stage.sv */
// ex_stage: execute stage top, dispatcher plus functional units
`timescale 1ns/10ps
`include "ex_defines.svh"

module ex_stage (
    input  logic                   clk,
    input  logic                   arst_n,
    input  ex_pkg::idex_t          idex,
    input  logic [`DATA_WIDTH-1:0] csr_rdata,
    input  logic                   dcache_en,
    output ex_pkg::ex_result_t     ex_out,
    output logic                   stall_req
);
    alu_pkg::arith_req_t    arith_req;
    alu_pkg::bitwise_req_t  bitwise_req;
    logic [`DATA_WIDTH-1:0] arith_result;
    logic [`ADDR_WIDTH-1:0] branch_target;
    logic [`DATA_WIDTH-1:0] bitwise_result;
    logic [`DATA_WIDTH-1:0] div_dividend;
    logic [`DATA_WIDTH-1:0] div_divisor;
    logic [`DATA_WIDTH-1:0] div_quotient;
    logic [`DATA_WIDTH-1:0] div_remainder;
    logic                   div_start;
    logic                   div_ready;

    alu_dispatcher u_dispatch (
        .idex           (idex),
        .csr_rdata      (csr_rdata),
        .dcache_en      (dcache_en),
        .arith_result   (arith_result),
        .branch_target  (branch_target),
        .bitwise_result (bitwise_result),
        .div_quotient   (div_quotient),
        .div_remainder  (div_remainder),
        .div_ready      (div_ready),
        .arith_req      (arith_req),
        .bitwise_req    (bitwise_req),
        .div_dividend   (div_dividend),
        .div_divisor    (div_divisor),
        .div_start      (div_start),
        .ex_out         (ex_out)
    );

    arith_unit u_arith (
        .req           (arith_req),
        .result        (arith_result),
        .branch_target (branch_target)
    );

    // logic ops share the second operand with the adder
    bitwise_unit u_bitwise (
        .req    (bitwise_req),
        .b      (arith_req.b),
        .result (bitwise_result)
    );

    seq_divider #(
        .DLEN (`DATA_WIDTH)
    ) u_div (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (div_start),
        .dividend  (div_dividend),
        .divisor   (div_divisor),
        .quotient  (div_quotient),
        .remainder (div_remainder),
        .ready     (div_ready)
    );

    // hold the pipeline until the divider finishes
    assign stall_req = div_start & ~div_ready;

endmodule

/* testbench/tb_ex_stage.sv */
// testbench for the execute stage, directed and random ops
// RV32IM reference model, immediate assertion checks
`timescale 1ns/10ps
`include "ex_defines.svh"

module tb_ex_stage;
    localparam int W = `DATA_WIDTH;
    localparam int DIV_TIMEOUT = 4 * `DIV_STEPS;
    localparam logic [W-1:0] MOST_NEG = {1'b1, {(W-1){1'b0}}};

    logic               clk;
    logic               arst_n;
    ex_pkg::idex_t      idex;
    logic [W-1:0]       csr_rdata;
    logic               dcache_en;
    ex_pkg::ex_result_t ex_out;
    logic               stall_req;
    integer             seed;
    integer             errors;
    integer             timeouts;

    ex_stage i_ex_stage (
        .clk       (clk),
        .arst_n    (arst_n),
        .idex      (idex),
        .csr_rdata (csr_rdata),
        .dcache_en (dcache_en),
        .ex_out    (ex_out),
        .stall_req (stall_req)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    function automatic logic [W-1:0] rand_word();
        rand_word = $random(seed);
    endfunction

    // corner operands first, random beyond them
    function automatic logic [W-1:0] operand_value(input int idx);
        case (idx)
            0:       operand_value = '0;
            1:       operand_value = W'(1);
            2:       operand_value = '1;
            3:       operand_value = MOST_NEG;
            4:       operand_value = ~MOST_NEG;
            default: operand_value = rand_word();
        endcase
    endfunction

    function automatic ex_pkg::idex_t make_op(input alu_pkg::alu_op_e code,
            input logic [W-1:0] rs1, input logic [W-1:0] rs2,
            input logic sel_pc, input logic sel_imm);
        ex_pkg::idex_t op;
        op          = '0;
        op.alu_op   = code;
        op.rs1_data = rs1;
        op.rs2_data = rs2;
        op.pc       = rand_word();
        op.pc[1:0]  = 2'b00;
        op.imm      = rand_word();
        op.imm[0]   = 1'b0;
        op.sel_pc   = sel_pc;
        op.sel_imm  = sel_imm;
        return op;
    endfunction

    function automatic ex_pkg::ex_result_t model_result(input ex_pkg::idex_t op,
            input logic [W-1:0] csr, input logic dc);
        ex_pkg::ex_result_t r;
        logic [W-1:0]       a;
        logic [W-1:0]       b;
        logic [W-1:0]       tgt;
        logic [2*W-1:0]     prod;
        a    = op.sel_pc ? op.pc : op.rs1_data;
        b    = op.sel_imm ? op.imm : op.rs2_data;
        r    = '0;
        prod = '0;
        tgt  = op.pc + op.imm;
        r.branch_pc = tgt;
        case (op.alu_op)
            alu_pkg::ALU_ADD:   r.alu_data = a + b;
            alu_pkg::ALU_SUB:   r.alu_data = a - b;
            alu_pkg::ALU_SLL:   r.alu_data = a << b[4:0];
            alu_pkg::ALU_SRL:   r.alu_data = a >> b[4:0];
            alu_pkg::ALU_SRA:   r.alu_data = $signed(a) >>> b[4:0];
            alu_pkg::ALU_SLT:   r.alu_data = W'($signed(a) < $signed(b));
            alu_pkg::ALU_SLTU:  r.alu_data = W'(a < b);
            alu_pkg::ALU_AND:   r.alu_data = a & b;
            alu_pkg::ALU_OR:    r.alu_data = a | b;
            alu_pkg::ALU_XOR:   r.alu_data = a ^ b;
            alu_pkg::ALU_LUI:   r.alu_data = op.imm;
            alu_pkg::ALU_AUIPC: r.alu_data = op.pc + op.imm;
            alu_pkg::ALU_CSR:   r.alu_data = csr;
            alu_pkg::ALU_JAL, alu_pkg::ALU_JALR: begin
                r.alu_data     = op.pc + (op.half_inst ? W'(2) : W'(4));
                r.branch_taken = 1'b1;
                if (op.alu_op == alu_pkg::ALU_JALR) begin
                    tgt = op.rs1_data + op.imm;
                end
                r.branch_pc = {tgt[W-1:1], 1'b0};
            end
            alu_pkg::ALU_BEQ:  r.branch_taken = (op.rs1_data == op.rs2_data);
            alu_pkg::ALU_BNE:  r.branch_taken = (op.rs1_data != op.rs2_data);
            alu_pkg::ALU_BLT:  r.branch_taken = ($signed(op.rs1_data) < $signed(op.rs2_data));
            alu_pkg::ALU_BGE:  r.branch_taken = ($signed(op.rs1_data) >= $signed(op.rs2_data));
            alu_pkg::ALU_BLTU: r.branch_taken = (op.rs1_data < op.rs2_data);
            alu_pkg::ALU_BGEU: r.branch_taken = (op.rs1_data >= op.rs2_data);
            alu_pkg::ALU_MUL:  r.alu_data = a * b;
            alu_pkg::ALU_MULH: begin
                prod       = {{W{a[W-1]}}, a} * {{W{b[W-1]}}, b};
                r.alu_data = prod[2*W-1:W];
            end
            alu_pkg::ALU_MULHSU: begin
                prod       = {{W{a[W-1]}}, a} * {{W{1'b0}}, b};
                r.alu_data = prod[2*W-1:W];
            end
            alu_pkg::ALU_MULHU: begin
                prod       = {{W{1'b0}}, a} * {{W{1'b0}}, b};
                r.alu_data = prod[2*W-1:W];
            end
            alu_pkg::ALU_DIVU: r.alu_data = (b == '0) ? '1 : a / b;
            alu_pkg::ALU_REMU: r.alu_data = (b == '0) ? a : a % b;
            alu_pkg::ALU_DIV, alu_pkg::ALU_REM: begin
                if (b == '0) begin
                    r.alu_data = (op.alu_op == alu_pkg::ALU_DIV) ? '1 : a;
                end else if (a == MOST_NEG && b == '1) begin
                    r.alu_data = (op.alu_op == alu_pkg::ALU_DIV) ? a : '0;
                end else if (op.alu_op == alu_pkg::ALU_DIV) begin
                    r.alu_data = $signed(a) / $signed(b);
                end else begin
                    r.alu_data = $signed(a) % $signed(b);
                end
            end
            default: r.alu_data = '0;
        endcase
        r.ld_st = dc && (op.ld_type != ex_pkg::LD_NONE || op.st_type != ex_pkg::ST_NONE);
        return r;
    endfunction

    task automatic compare_outputs(input ex_pkg::idex_t op, input ex_pkg::ex_result_t exp);
        logic br;
        logic jmp;
        br  = op.alu_op inside {alu_pkg::ALU_BEQ, alu_pkg::ALU_BNE, alu_pkg::ALU_BLT,
                                alu_pkg::ALU_BGE, alu_pkg::ALU_BLTU, alu_pkg::ALU_BGEU};
        jmp = op.alu_op inside {alu_pkg::ALU_JAL, alu_pkg::ALU_JALR};
        if (!br) begin
            assert (ex_out.alu_data == exp.alu_data) else begin
                $display("FAILED %0t: op %0d alu_data %h, expected %h", $time,
                         op.alu_op, ex_out.alu_data, exp.alu_data);
                errors++;
            end
        end
        if (br || jmp) begin
            assert (ex_out.branch_pc == exp.branch_pc) else begin
                $display("FAILED %0t: op %0d branch_pc %h, expected %h", $time,
                         op.alu_op, ex_out.branch_pc, exp.branch_pc);
                errors++;
            end
        end
        assert (ex_out.branch_taken == exp.branch_taken) else begin
            $display("FAILED %0t: op %0d branch_taken %b, expected %b", $time,
                     op.alu_op, ex_out.branch_taken, exp.branch_taken);
            errors++;
        end
        assert (ex_out.ld_st == exp.ld_st) else begin
            $display("FAILED %0t: ld_st %b, expected %b", $time, ex_out.ld_st, exp.ld_st);
            errors++;
        end
    endtask

    task automatic apply_op(input ex_pkg::idex_t op, input logic [W-1:0] csr,
            input logic dc);
        @(posedge clk);
        idex      <= op;
        csr_rdata <= csr;
        dcache_en <= dc;
        @(negedge clk);
        assert (!stall_req) else begin
            $display("FAILED %0t: stall_req high for op %0d", $time, op.alu_op);
            errors++;
        end
        compare_outputs(op, model_result(op, csr, dc));
    endtask

    task automatic apply_div(input ex_pkg::idex_t op);
        ex_pkg::ex_result_t exp;
        int                 cycles;
        exp = model_result(op, csr_rdata, dcache_en);
        @(posedge clk);
        idex <= op;
        @(negedge clk);
        assert (stall_req) else begin
            $display("FAILED %0t: stall_req low at divide op %0d", $time, op.alu_op);
            errors++;
        end
        cycles = 0;
        while (stall_req && cycles <= DIV_TIMEOUT) begin
            cycles++;
            @(negedge clk);
        end
        if (stall_req) begin
            $display("divider timeout at %0t: stall_req still high after %0d cycles",
                     $time, cycles);
            timeouts++;
        end else begin
            assert (cycles == `DIV_STEPS + 1) else begin
                $display("FAILED %0t: stall lasted %0d cycles, expected %0d", $time,
                         cycles, `DIV_STEPS + 1);
                errors++;
            end
            compare_outputs(op, exp);
        end
        // a bubble lets the divider return to idle
        @(posedge clk);
        idex <= '0;
    endtask

    initial begin
        ex_pkg::idex_t op;
        logic [W-1:0]  a;
        logic [W-1:0]  r;
        seed      = 32'hf14a;
        errors    = 0;
        timeouts  = 0;
        arst_n    = 1'b0;
        idex      = '0;
        csr_rdata = '0;
        dcache_en = 1'b0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        assert (!stall_req) else begin
            $display("FAILED %0t: stall_req high after reset", $time);
            errors++;
        end

        // ADD through AUIPC, all four operand selects
        for (int i = 0; i < 16; i++) begin
            for (int k = int'(alu_pkg::ALU_ADD); k <= int'(alu_pkg::ALU_AUIPC); k++) begin
                op = make_op(alu_pkg::alu_op_e'(k), rand_word(), rand_word(), i[0], i[1]);
                apply_op(op, '0, 1'b0);
            end
        end

        for (int i = 0; i < 12; i++) begin
            for (int k = int'(alu_pkg::ALU_BEQ); k <= int'(alu_pkg::ALU_BGEU); k++) begin
                a  = rand_word();
                op = make_op(alu_pkg::alu_op_e'(k), a, i[0] ? a : rand_word(), 1'b0, 1'b1);
                apply_op(op, '0, 1'b0);
            end
            // compressed link on odd passes
            for (int k = int'(alu_pkg::ALU_JAL); k <= int'(alu_pkg::ALU_JALR); k++) begin
                op = make_op(alu_pkg::alu_op_e'(k), rand_word(), rand_word(), 1'b1, 1'b1);
                op.half_inst = i[0];
                apply_op(op, '0, 1'b0);
            end
        end

        for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < 8; j++) begin
                for (int k = int'(alu_pkg::ALU_MUL); k <= int'(alu_pkg::ALU_MULHU); k++) begin
                    op = make_op(alu_pkg::alu_op_e'(k), operand_value(i), operand_value(j),
                                 1'b0, 1'b0);
                    apply_op(op, '0, 1'b0);
                end
                for (int k = int'(alu_pkg::ALU_DIV); k <= int'(alu_pkg::ALU_REMU); k++) begin
                    op = make_op(alu_pkg::alu_op_e'(k), operand_value(i), operand_value(j),
                                 1'b0, 1'b0);
                    apply_div(op);
                end
            end
        end

        // loads and stores, address is rs1 + imm
        for (int i = 0; i < 24; i++) begin
            r  = rand_word();
            op = make_op(alu_pkg::ALU_ADD, rand_word(), rand_word(), 1'b0, 1'b1);
            op.ld_type = ex_pkg::ld_type_e'(3'(r % 6));
            op.st_type = ex_pkg::st_type_e'(r[5:4]);
            apply_op(op, '0, r[8]);
        end

        for (int i = 0; i < 8; i++) begin
            op = make_op(alu_pkg::ALU_CSR, rand_word(), rand_word(), 1'b0, 1'b0);
            apply_op(op, rand_word(), i[0]);
        end

        $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+src
src/alu_pkg.sv
src/ex_pkg.sv
src/arith_unit.sv
src/bitwise_unit.sv
src/seq_divider.sv
src/alu_dispatcher.sv
src/ex_stage.sv
testbench/tb_ex_stage.sv

/* run_sim.sh */
#!/bin/sh
# build the execute stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tb_ex_stage --Mdir "$OBJ" -o sim_ex_stage
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/sim_ex_stage" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi
exit 0
